// File: common/ffp_cfg_pkg.sv
// ------------------------------
// Feedforward pulser configuration
// Sizing and register map shared
// by the register block and the
// pulse channels
// ------------------------------
package ffp_cfg_pkg;

   // Sizing
   localparam int N_CH      = 4;   // Number of pulser channels
   localparam int LENGTH_WI = 20;  // Pulse length counter width
   localparam int DWI       = 18;  // Signed setpoint and sample width

   // AXI4-Lite bus widths
   localparam int AXIL_AW = 12;
   localparam int AXIL_DW = 32;

   // Register map, byte addresses
   localparam logic [AXIL_AW-1:0] ADDR_CTRL      = 12'h000; // W: start bits, R: busy bits
   localparam logic [AXIL_AW-1:0] ADDR_LENGTH    = 12'h004; // Shared pulse length
   localparam logic [AXIL_AW-1:0] ADDR_SLEW      = 12'h008; // Shared slew limit
   localparam logic [AXIL_AW-1:0] ADDR_SETP_BASE = 12'h100;

   // Channel c owns two words at ADDR_SETP_BASE + 8c
   localparam int SETP_STRIDE = 8;  // x at +0, y at +4

endpackage

// File: common/ffp_types_pkg.sv
// ------------------------------
// Feedforward pulser types
// AXI4-Lite channel bundles and
// per-channel setting and sample
// pairs
// ------------------------------
package ffp_types_pkg;
   import ffp_cfg_pkg::*;

   // Master-driven AXI4-Lite signals
   typedef struct packed {
      logic [AXIL_AW-1:0] awaddr;
      logic               awvalid;
      logic [AXIL_DW-1:0] wdata;
      logic               wvalid;
      logic               bready;
      logic [AXIL_AW-1:0] araddr;
      logic               arvalid;
      logic               rready;
   } axil_req_t;

   // Slave-driven AXI4-Lite signals
   typedef struct packed {
      logic               awready;
      logic               wready;
      logic               bvalid;
      logic [1:0]         bresp;
      logic               arready;
      logic               rvalid;
      logic [AXIL_DW-1:0] rdata;
      logic [1:0]         rresp;
   } axil_rsp_t;

   // Setpoint pair of one channel, I/Q or magnitude/phase
   typedef struct packed {
      logic signed [DWI-1:0] setp_x;
      logic signed [DWI-1:0] setp_y;
   } chan_cfg_t;

   // Output pair of one channel, also used for the summed drive
   typedef struct packed {
      logic signed [DWI-1:0] out_x;
      logic signed [DWI-1:0] out_y;
   } chan_out_t;

endpackage

// File: ff_pulser/ff_pulser.sv
// ------------------------------
// Feedforward pulse channel
// Slew-limited rise, flat top and
// mirrored fall of a setpoint pair
// Busy spans length + 3 cycles
// ------------------------------
module ff_pulser #(
   parameter int LENGTH_WI = 20,
   parameter int DWI       = 18
) (
   input  logic                       clk,
   input  logic                       arst_n,
   input  logic                       start,
   input  logic [LENGTH_WI-1:0]       length,      // Whole pulse, rise and fall included
   input  logic [DWI-2:0]             slew_limit,  // Magnitude step per cycle
   input  ffp_types_pkg::chan_cfg_t   cfg,
   output logic                       busy,
   output ffp_types_pkg::chan_out_t   out
);
   import ffp_types_pkg::*;

   logic                 start_g;
   logic [1:0]           start_sr;       // First two stages of the start delay
   logic                 pulse_on, run, rise_done;
   logic [LENGTH_WI-1:0] run_cnt, rise_cnt;
   logic [DWI-2:0]       tgt_x, tgt_y, mag_x, mag_y;
   logic                 neg_x, neg_y;
   logic                 both_railed, done, falling, stop;
   chan_out_t            out_r;

   // Unsigned magnitude of a signed setpoint
   function automatic logic [DWI-2:0] magnitude(input logic [DWI-1:0] v);
      logic [DWI-1:0] neg;
      neg = -v;
      if (!v[DWI-1])
         return v[DWI-2:0];
      else if (neg[DWI-1])
         return '1;  // Most negative code saturates
      else
         return neg[DWI-2:0];
   endfunction

   // One slew step toward the target, or toward zero on the fall
   function automatic logic [DWI-2:0] step(input logic [DWI-2:0] mag, input logic [DWI-2:0] tgt,
                                           input logic [DWI-2:0] slew, input logic down);
      logic [DWI-1:0] up;
      up = {1'b0, mag} + {1'b0, slew};
      if (down)
         return (mag > slew) ? mag - slew : '0;
      else
         return (up >= {1'b0, tgt}) ? tgt : up[DWI-2:0];
   endfunction

   assign start_g     = start & ~pulse_on;  // Restart ignored while busy
   assign both_railed = (mag_x == tgt_x) && (mag_y == tgt_y);
   assign done        = rise_done | both_railed;
   // Fall begins rise_cnt + 1 cycles before the end so the last step lands on zero
   assign falling = done && ({1'b0, run_cnt} + {1'b0, rise_cnt} + 1'b1 >= {1'b0, length});
   assign stop    = ({1'b0, run_cnt} + (LENGTH_WI+1)'(2)) >= {1'b0, length};

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         start_sr  <= '0;
         pulse_on  <= 1'b0;
         run       <= 1'b0;
         run_cnt   <= '0;
         rise_cnt  <= '0;
         rise_done <= 1'b0;
      end else begin
         start_sr <= {start_sr[0], start_g};
         if (start_g) begin
            pulse_on  <= 1'b1;
            run_cnt   <= '0;
            rise_cnt  <= '0;
            rise_done <= 1'b0;
         end
         if (start_sr[1]) run <= 1'b1;  // Ramp starts three cycles after start
         if (run) begin
            run_cnt <= run_cnt + 1'b1;
            if (both_railed)
               rise_done <= 1'b1;
            else if (!rise_done)
               rise_cnt <= rise_cnt + 1'b1;
            if (run_cnt == length) begin
               pulse_on <= 1'b0;
               run      <= 1'b0;
            end
         end
      end
   end

   // Magnitude ramp, both axes stepped together
   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         tgt_x <= '0;
         tgt_y <= '0;
         neg_x <= 1'b0;
         neg_y <= 1'b0;
         mag_x <= '0;
         mag_y <= '0;
      end else begin
         tgt_x <= magnitude(cfg.setp_x);
         tgt_y <= magnitude(cfg.setp_y);
         neg_x <= cfg.setp_x[DWI-1];
         neg_y <= cfg.setp_y[DWI-1];
         if (!run || stop) begin
            mag_x <= '0;  // Hard end of pulse
            mag_y <= '0;
         end else begin
            mag_x <= step(mag_x, tgt_x, slew_limit, falling);
            mag_y <= step(mag_y, tgt_y, slew_limit, falling);
         end
      end
   end

   // Sign restore, then one more register stage
   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         out_r <= '0;
         out   <= '0;
      end else begin
         out_r.out_x <= neg_x ? -$signed({1'b0, mag_x}) : $signed({1'b0, mag_x});
         out_r.out_y <= neg_y ? -$signed({1'b0, mag_y}) : $signed({1'b0, mag_y});
         out         <= out_r;
      end
   end

   assign busy = pulse_on;

endmodule

// File: ffp_top.f
common/ffp_cfg_pkg.sv
common/ffp_types_pkg.sv
src/ffp_regs.sv
ff_pulser/ff_pulser.sv
src/ffp_combiner.sv
src/ffp_top.sv
tests/tb_clock.sv
tests/ffp_properties.sv
tests/ffp_tb.sv

// File: run.sh
#!/bin/sh
# Compile and run the pulser testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ps \
   -f ffp_top.f --top-module ffp_tb -o ffp_sim
if [ $? -ne 0 ]; then
   echo "Verilator build failed"
   exit 1
fi

out=$(./obj_dir/ffp_sim)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
   echo "Simulation exited with status $status"
   exit 1
fi

if echo "$out" | grep -q "ALL TESTS PASSED"; then
   exit 0
fi
exit 1

// File: src/ffp_combiner.sv
// ------------------------------
// Channel combiner
// Sums all channel pairs and
// clamps to the output width
// ------------------------------
module ffp_combiner #(
   parameter int N_CH = 4,
   parameter int DWI  = 18
) (
   input  logic                                clk,
   input  logic                                arst_n,
   input  ffp_types_pkg::chan_out_t [N_CH-1:0] chan_out,
   output ffp_types_pkg::chan_out_t            drive
);
   localparam int SW = DWI + $clog2(N_CH) + 1;  // Headroom for the full sum
   localparam logic signed [SW-1:0] POS_RAIL = SW'((1 <<< (DWI-1)) - 1);
   localparam logic signed [SW-1:0] NEG_RAIL = -POS_RAIL - 1;

   logic signed [SW-1:0] sum_x, sum_y;

   function automatic logic signed [DWI-1:0] clamp(input logic signed [SW-1:0] s);
      if (s > POS_RAIL)
         return POS_RAIL[DWI-1:0];
      else if (s < NEG_RAIL)
         return NEG_RAIL[DWI-1:0];
      else
         return s[DWI-1:0];
   endfunction

   always_comb begin
      sum_x = '0;
      sum_y = '0;
      for (int i = 0; i < N_CH; i++) begin
         sum_x = sum_x + SW'($signed(chan_out[i].out_x));
         sum_y = sum_y + SW'($signed(chan_out[i].out_y));
      end
   end

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         drive <= '0;
      end else begin
         drive.out_x <= clamp(sum_x);
         drive.out_y <= clamp(sum_y);
      end
   end

endmodule

// File: src/ffp_regs.sv
// ------------------------------
// Pulser register block
// AXI4-Lite slave holding shared
// and per-channel settings, start
// pulses and busy readback
// ------------------------------
module ffp_regs #(
   parameter int N_CH      = ffp_cfg_pkg::N_CH,
   parameter int LENGTH_WI = ffp_cfg_pkg::LENGTH_WI,
   parameter int DWI       = ffp_cfg_pkg::DWI
) (
   input  logic                                 clk,
   input  logic                                 arst_n,
   input  ffp_types_pkg::axil_req_t             axil_req,
   input  logic [N_CH-1:0]                      busy,
   output ffp_types_pkg::axil_rsp_t             axil_rsp,
   output logic [LENGTH_WI-1:0]                 length,
   output logic [DWI-2:0]                       slew_limit,
   output ffp_types_pkg::chan_cfg_t [N_CH-1:0]  chan_cfg,
   output logic [N_CH-1:0]                      start
);
   import ffp_cfg_pkg::*;

   logic               awready, wready, bvalid, arready, rvalid;
   logic [AXIL_DW-1:0] rdata, rdata_nxt;
   logic               bus_idle, wr_fire, rd_fire;
   logic [AXIL_AW-1:0] w_off, r_off;

   // Offset into the setpoint window; addresses below the base wrap high and miss
   function automatic logic setp_hit(input logic [AXIL_AW-1:0] off);
      return (off < AXIL_AW'(SETP_STRIDE * N_CH)) && (off[1:0] == 2'b00);
   endfunction

   function automatic logic [AXIL_DW-1:0] sext(input logic [DWI-1:0] v);
      return {{(AXIL_DW-DWI){v[DWI-1]}}, v};
   endfunction

   assign bus_idle = !(awready | arready | bvalid | rvalid);  // One transaction at a time
   assign wr_fire  = awready & wready & axil_req.awvalid & axil_req.wvalid;
   assign rd_fire  = arready & axil_req.arvalid;
   assign w_off    = axil_req.awaddr - ADDR_SETP_BASE;
   assign r_off    = axil_req.araddr - ADDR_SETP_BASE;

   // Read data select
   always_comb begin
      rdata_nxt = '0;  // Unmapped reads return zero
      case (axil_req.araddr)
         ADDR_CTRL:   rdata_nxt = AXIL_DW'(busy);
         ADDR_LENGTH: rdata_nxt = AXIL_DW'(length);
         ADDR_SLEW:   rdata_nxt = AXIL_DW'(slew_limit);
         default: begin
            for (int c = 0; c < N_CH; c++) begin
               if (setp_hit(r_off) && r_off[AXIL_AW-1:3] == (AXIL_AW-3)'(c))
                  rdata_nxt = r_off[2] ? sext(chan_cfg[c].setp_y) : sext(chan_cfg[c].setp_x);
            end
         end
      endcase
   end

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         awready    <= 1'b0;
         wready     <= 1'b0;
         arready    <= 1'b0;
         bvalid     <= 1'b0;
         rvalid     <= 1'b0;
         start      <= '0;
         length     <= '0;
         slew_limit <= '0;
         chan_cfg   <= '0;
      end else begin
         start   <= '0;  // Start bits are single-cycle pulses
         awready <= 1'b0;
         wready  <= 1'b0;
         arready <= 1'b0;

         // Write needs both AW and W; it wins over a read in the same cycle
         if (bus_idle && axil_req.awvalid && axil_req.wvalid) begin
            awready <= 1'b1;
            wready  <= 1'b1;
         end else if (bus_idle && axil_req.arvalid) begin
            arready <= 1'b1;
         end

         if (wr_fire) begin
            bvalid <= 1'b1;
            case (axil_req.awaddr)
               ADDR_CTRL:   start      <= axil_req.wdata[N_CH-1:0];
               ADDR_LENGTH: length     <= axil_req.wdata[LENGTH_WI-1:0];
               ADDR_SLEW:   slew_limit <= axil_req.wdata[DWI-2:0];
               default: begin
                  for (int c = 0; c < N_CH; c++) begin
                     if (setp_hit(w_off) && w_off[AXIL_AW-1:3] == (AXIL_AW-3)'(c)) begin
                        if (w_off[2])
                           chan_cfg[c].setp_y <= axil_req.wdata[DWI-1:0];
                        else
                           chan_cfg[c].setp_x <= axil_req.wdata[DWI-1:0];
                     end
                  end
               end
            endcase
         end else if (bvalid && axil_req.bready) begin
            bvalid <= 1'b0;
         end

         if (rd_fire)
            rvalid <= 1'b1;
         else if (rvalid && axil_req.rready)
            rvalid <= 1'b0;
      end
   end

   // Read data holds while rvalid waits for rready
   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n)
         rdata <= '0;
      else if (rd_fire)
         rdata <= rdata_nxt;
   end

   assign axil_rsp.awready = awready;
   assign axil_rsp.wready  = wready;
   assign axil_rsp.bvalid  = bvalid;
   assign axil_rsp.bresp   = 2'b00;  // Always OKAY
   assign axil_rsp.arready = arready;
   assign axil_rsp.rvalid  = rvalid;
   assign axil_rsp.rdata   = rdata;
   assign axil_rsp.rresp   = 2'b00;

endmodule

// File: src/ffp_top.sv
// ------------------------------
// Feedforward pulser top
// Register block, pulse channels
// and output combiner
// ------------------------------
module ffp_top #(
   parameter int N_CH      = ffp_cfg_pkg::N_CH,
   parameter int LENGTH_WI = ffp_cfg_pkg::LENGTH_WI,
   parameter int DWI       = ffp_cfg_pkg::DWI
) (
   input  logic                      clk,
   input  logic                      arst_n,
   input  ffp_types_pkg::axil_req_t  axil_req,
   output ffp_types_pkg::axil_rsp_t  axil_rsp,
   output ffp_types_pkg::chan_out_t  drive,
   output logic [N_CH-1:0]           busy
);
   import ffp_types_pkg::*;

   logic [LENGTH_WI-1:0]   length;
   logic [DWI-2:0]         slew_limit;
   logic [N_CH-1:0]        start;
   chan_cfg_t [N_CH-1:0]   chan_cfg;
   chan_out_t [N_CH-1:0]   chan_out;

   ffp_regs #(.N_CH(N_CH), .LENGTH_WI(LENGTH_WI), .DWI(DWI)) u_regs (
      .clk        (clk),
      .arst_n     (arst_n),
      .axil_req   (axil_req),
      .busy       (busy),
      .axil_rsp   (axil_rsp),
      .length     (length),
      .slew_limit (slew_limit),
      .chan_cfg   (chan_cfg),
      .start      (start)
   );

   for (genvar i = 0; i < N_CH; i++) begin : g_ch
      ff_pulser #(.LENGTH_WI(LENGTH_WI), .DWI(DWI)) u_pulser (
         .clk        (clk),
         .arst_n     (arst_n),
         .start      (start[i]),
         .length     (length),
         .slew_limit (slew_limit),
         .cfg        (chan_cfg[i]),
         .busy       (busy[i]),
         .out        (chan_out[i])
      );
   end

   ffp_combiner #(.N_CH(N_CH), .DWI(DWI)) u_comb (
      .clk      (clk),
      .arst_n   (arst_n),
      .chan_out (chan_out),
      .drive    (drive)
   );

endmodule

// File: tests/ffp_properties.sv
// ------------------------------
// Pulser bus and busy properties
// AXI4-Lite response holding and
// start to busy relation
// ------------------------------
module ffp_properties #(
   parameter int N_CH = ffp_cfg_pkg::N_CH
) (
   input  logic                      clk,
   input  logic                      arst_n,
   input  ffp_types_pkg::axil_req_t  axil_req,
   input  ffp_types_pkg::axil_rsp_t  axil_rsp,
   input  logic [N_CH-1:0]           start,
   input  logic [N_CH-1:0]           busy
);
   timeunit 1ns;
   timeprecision 1ps;

   int fail_count = 0;  // Read by the testbench summary

   // Write response waits for bready
   bvalid_hold: assert property (@(posedge clk) disable iff (!arst_n)
      axil_rsp.bvalid && !axil_req.bready |=> axil_rsp.bvalid)
      else begin
         $error("bvalid dropped before bready");
         fail_count++;
      end

   // Read response and its data hold until rready
   rvalid_hold: assert property (@(posedge clk) disable iff (!arst_n)
      axil_rsp.rvalid && !axil_req.rready |=> axil_rsp.rvalid && $stable(axil_rsp.rdata))
      else begin
         $error("rvalid or rdata changed before rready");
         fail_count++;
      end

   start_busy: assert property (@(posedge clk) disable iff (!arst_n)
      (start != '0) |=> ((busy & $past(start)) == $past(start)))
      else begin
         $error("busy not set on the cycle after a start pulse");
         fail_count++;
      end

   // A channel only turns busy from a start pulse
   busy_from_start: assert property (@(posedge clk) disable iff (!arst_n)
      (busy & ~$past(busy) & ~$past(start)) == '0)
      else begin
         $error("busy rose without a start pulse");
         fail_count++;
      end

endmodule

bind ffp_top ffp_properties #(.N_CH(N_CH)) u_props (
   .clk      (clk),
   .arst_n   (arst_n),
   .axil_req (axil_req),
   .axil_rsp (axil_rsp),
   .start    (start),
   .busy     (busy)
);

// File: tests/ffp_tb.sv
// ------------------------------
// Feedforward pulser testbench
// Directed tests for register
// access, pulse timing, slew,
// summing with saturation and
// restart while busy
// ------------------------------
module ffp_tb;
   timeunit 1ns;
   timeprecision 1ps;
   import ffp_cfg_pkg::*;
   import ffp_types_pkg::*;

   localparam int CLK_PERIOD_NS = 10;
   localparam int HS_LIMIT      = 16;   // Cycles allowed for one bus handshake
   localparam int LEN_SINGLE    = 200;
   localparam int LEN_SLEW      = 400;
   localparam int LEN_MULTI     = 300;
   localparam int LEN_RESTART   = 240;
   localparam int SLEW_SMALL    = 37;
   localparam int WATCHDOG_CYCLES =
      2 * (LEN_SINGLE + LEN_SLEW + 2 * LEN_MULTI + LEN_RESTART) + 1000;

   logic                   clk, arst_n;
   axil_req_t              req;
   axil_rsp_t              rsp;
   chan_out_t              drive;
   logic [N_CH-1:0]        busy;
   logic signed [DWI-1:0]  sp_x [N_CH];  // Setpoints as last written
   logic signed [DWI-1:0]  sp_y [N_CH];
   integer                 seed;
   int                     cyc = 0;
   int                     errors, tests_passed, tests_failed;

   tb_clock #(.PERIOD_NS(CLK_PERIOD_NS), .RESET_CYCLES(8)) u_clock (
      .clk    (clk),
      .arst_n (arst_n)
   );

   ffp_top #(.N_CH(N_CH), .LENGTH_WI(LENGTH_WI), .DWI(DWI)) u_dut (
      .clk      (clk),
      .arst_n   (arst_n),
      .axil_req (req),
      .axil_rsp (rsp),
      .drive    (drive),
      .busy     (busy)
   );

   always @(posedge clk) cyc <= cyc + 1;

   task automatic check(input string name, input int expected, input int actual);
      if (expected !== actual) begin
         $display("MISMATCH at %0d ns: %s expected %0d, got %0d", $time, name, expected, actual);
         errors++;
      end
   endtask

   function automatic int abs_val(input int v);
      return (v < 0) ? -v : v;
   endfunction

   // Flat top of one channel; the magnitude path cannot hold the most negative code
   function automatic int flat_value(input logic signed [DWI-1:0] v);
      if (int'(v) == -(1 << (DWI - 1)))
         return -((1 << (DWI - 1)) - 1);
      return int'(v);
   endfunction

   function automatic int clamp_sum(input int s);
      if (s > (1 << (DWI - 1)) - 1)
         return (1 << (DWI - 1)) - 1;
      if (s < -(1 << (DWI - 1)))
         return -(1 << (DWI - 1));
      return s;
   endfunction

   // Expected flat-top drive for the channels in mask
   function automatic int model_drive(input logic [N_CH-1:0] mask, input logic axis_y);
      int sum;
      sum = 0;
      for (int c = 0; c < N_CH; c++)
         if (mask[c]) sum += flat_value(axis_y ? sp_y[c] : sp_x[c]);
      return clamp_sum(sum);
   endfunction

   function automatic logic signed [DWI-1:0] rand_setp();
      int r;
      r = $random(seed);
      return r[DWI-1:0];
   endfunction

   // Callers sit on a falling edge; all bus signals change there
   task automatic axil_write(input logic [AXIL_AW-1:0] addr, input logic [AXIL_DW-1:0] data);
      int n;
      req.awaddr  = addr;
      req.wdata   = data;
      req.awvalid = 1'b1;
      req.wvalid  = 1'b1;
      n = 0;
      while (!(rsp.awready && rsp.wready) && n < HS_LIMIT) begin
         @(negedge clk);
         n++;
      end
      if (n >= HS_LIMIT) begin
         $display("ERROR: write to 0x%03h was never accepted", addr);
         errors++;
         req.awvalid = 1'b0;
         req.wvalid  = 1'b0;
         return;
      end
      @(negedge clk);  // Transfer happened on the rising edge just passed
      req.awvalid = 1'b0;
      req.wvalid  = 1'b0;
      req.bready  = 1'b1;
      n = 0;
      while (!rsp.bvalid && n < HS_LIMIT) begin
         @(negedge clk);
         n++;
      end
      if (n >= HS_LIMIT) begin
         $display("ERROR: no write response for address 0x%03h", addr);
         errors++;
      end else begin
         check("bresp", 0, int'(rsp.bresp));  // OKAY for every address
      end
      @(negedge clk);
      req.bready = 1'b0;
   endtask

   task automatic axil_read(input logic [AXIL_AW-1:0] addr, output logic [AXIL_DW-1:0] data);
      int n;
      data        = '0;
      req.araddr  = addr;
      req.arvalid = 1'b1;
      n = 0;
      while (!rsp.arready && n < HS_LIMIT) begin
         @(negedge clk);
         n++;
      end
      if (n >= HS_LIMIT) begin
         $display("ERROR: read of 0x%03h was never accepted", addr);
         errors++;
         req.arvalid = 1'b0;
         return;
      end
      @(negedge clk);
      req.arvalid = 1'b0;
      req.rready  = 1'b1;
      n = 0;
      while (!rsp.rvalid && n < HS_LIMIT) begin
         @(negedge clk);
         n++;
      end
      if (n >= HS_LIMIT) begin
         $display("ERROR: no read data for address 0x%03h", addr);
         errors++;
      end else begin
         check("rresp", 0, int'(rsp.rresp));
      end
      data = rsp.rdata;
      @(negedge clk);
      req.rready = 1'b0;
   endtask

   // Returns the cycle count at the first falling edge where busy[ch] has the level
   task automatic wait_busy(input int ch, input logic level, input int limit, output int at);
      int n;
      n = 0;
      while (busy[ch] !== level && n < limit) begin
         @(negedge clk);
         n++;
      end
      if (busy[ch] !== level) begin
         $display("ERROR: busy[%0d] did not reach %0b within %0d cycles", ch, level, limit);
         errors++;
      end
      at = cyc;
   endtask

   task automatic set_shared(input int len, input int slew);
      axil_write(ADDR_LENGTH, AXIL_DW'(len));
      axil_write(ADDR_SLEW, AXIL_DW'(slew));
   endtask

   task automatic set_setpoint(input int c, input logic signed [DWI-1:0] x,
                               input logic signed [DWI-1:0] y);
      sp_x[c] = x;
      sp_y[c] = y;
      axil_write(AXIL_AW'(ADDR_SETP_BASE + SETP_STRIDE * c), {{(AXIL_DW-DWI){x[DWI-1]}}, x});
      axil_write(AXIL_AW'(ADDR_SETP_BASE + SETP_STRIDE * c + 4), {{(AXIL_DW-DWI){y[DWI-1]}}, y});
   endtask

   // Start the channels in mask, check the flat top, busy length and return to zero
   task automatic run_pulse(input logic [N_CH-1:0] mask, input int len);
      int ch, t_rise, t_fall;
      ch = 0;
      for (int c = N_CH - 1; c >= 0; c--)
         if (mask[c]) ch = c;
      axil_write(ADDR_CTRL, AXIL_DW'(mask));
      wait_busy(ch, 1'b1, 20, t_rise);
      repeat (len / 2) @(negedge clk);
      check("drive.out_x", model_drive(mask, 1'b0), int'(drive.out_x));
      check("drive.out_y", model_drive(mask, 1'b1), int'(drive.out_y));
      check("busy", int'(mask), int'(busy));
      wait_busy(ch, 1'b0, len + 20, t_fall);
      check("busy cycles", len + 3, t_fall - t_rise);
      repeat (3) @(negedge clk);
      check("drive.out_x after pulse", 0, int'(drive.out_x));
      check("drive.out_y after pulse", 0, int'(drive.out_y));
   endtask

   task automatic finish_test(input string name, input int errors_before);
      if (errors == errors_before) begin
         tests_passed++;
         $display("[%0t] test %s: ok", $time, name);
      end else begin
         tests_failed++;
         $display("[%0t] test %s: failed with %0d errors", $time, name, errors - errors_before);
      end
   endtask

   task automatic register_access();
      int                 e0;
      logic [AXIL_DW-1:0] rd;
      e0 = errors;
      set_shared(LEN_SINGLE, 1500);
      for (int c = 0; c < N_CH; c++) set_setpoint(c, rand_setp(), rand_setp());
      axil_read(ADDR_LENGTH, rd);
      check("length", LEN_SINGLE, int'(rd));
      axil_read(ADDR_SLEW, rd);
      check("slew_limit", 1500, int'(rd));
      for (int c = 0; c < N_CH; c++) begin
         axil_read(AXIL_AW'(ADDR_SETP_BASE + SETP_STRIDE * c), rd);
         check($sformatf("setp_x[%0d]", c), int'(sp_x[c]), int'(rd));  // Sign-extended
         axil_read(AXIL_AW'(ADDR_SETP_BASE + SETP_STRIDE * c + 4), rd);
         check($sformatf("setp_y[%0d]", c), int'(sp_y[c]), int'(rd));
      end
      axil_read(ADDR_CTRL, rd);
      check("ctrl idle", 0, int'(rd));
      axil_read(12'h00c, rd);
      check("unmapped 0x00c", 0, int'(rd));
      axil_read(AXIL_AW'(ADDR_SETP_BASE + SETP_STRIDE * N_CH), rd);
      check("unmapped past setpoints", 0, int'(rd));
      axil_read(12'hffc, rd);
      check("unmapped 0xffc", 0, int'(rd));
      finish_test("register_access", e0);
   endtask

   task automatic single_pulse();
      int e0;
      e0 = errors;
      set_shared(LEN_SINGLE, 1500);  // Rise of 27 cycles
      set_setpoint(0, DWI'(40000), DWI'(25000));
      run_pulse(N_CH'(1), LEN_SINGLE);
      finish_test("single_pulse", e0);
   endtask

   task automatic negative_slew();
      int e0, t_rise, t_fall, over;
      int cur_x, cur_y, prev_x, prev_y;
      e0 = errors;
      set_shared(LEN_SLEW, SLEW_SMALL);
      set_setpoint(1, DWI'(-5000), DWI'(3000));
      axil_write(ADDR_CTRL, AXIL_DW'(2));
      wait_busy(1, 1'b1, 20, t_rise);
      prev_x = 0;
      prev_y = 0;
      over   = 0;
      repeat (LEN_SLEW / 2) begin  // Covers the whole rise
         @(negedge clk);
         cur_x = abs_val(int'(drive.out_x));
         cur_y = abs_val(int'(drive.out_y));
         if (abs_val(cur_x - prev_x) > SLEW_SMALL || abs_val(cur_y - prev_y) > SLEW_SMALL)
            over++;
         prev_x = cur_x;
         prev_y = cur_y;
      end
      check("rise steps above slew", 0, over);
      check("drive.out_x", model_drive(N_CH'(2), 1'b0), int'(drive.out_x));
      check("drive.out_y", model_drive(N_CH'(2), 1'b1), int'(drive.out_y));
      wait_busy(1, 1'b0, LEN_SLEW + 20, t_fall);
      check("busy cycles", LEN_SLEW + 3, t_fall - t_rise);
      finish_test("negative_slew", e0);
   endtask

   task automatic multi_channel();
      int e0;
      e0 = errors;
      set_shared(LEN_MULTI, 2000);
      for (int c = 0; c < N_CH; c++) set_setpoint(c, rand_setp(), rand_setp());
      run_pulse('1, LEN_MULTI);
      // Large setpoints push x to the top rail and y to the bottom one
      for (int c = 0; c < N_CH; c++) set_setpoint(c, DWI'(100000), DWI'(-100000));
      run_pulse('1, LEN_MULTI);
      finish_test("multi_channel", e0);
   endtask

   task automatic restart_ignored();
      int                 e0, t_rise, t_fall;
      logic [AXIL_DW-1:0] rd;
      e0 = errors;
      set_shared(LEN_RESTART, 3000);
      axil_write(ADDR_CTRL, AXIL_DW'(1));
      wait_busy(0, 1'b1, 20, t_rise);
      repeat (50) @(negedge clk);
      axil_write(ADDR_CTRL, AXIL_DW'(1));  // Second start while busy
      axil_read(ADDR_CTRL, rd);
      check("ctrl busy readback", 1, int'(rd));
      wait_busy(0, 1'b0, LEN_RESTART + 20, t_fall);
      check("busy cycles after restart", LEN_RESTART + 3, t_fall - t_rise);
      axil_read(ADDR_CTRL, rd);
      check("ctrl idle readback", 0, int'(rd));
      finish_test("restart_ignored", e0);
   endtask

   initial begin
      req          = '0;
      seed         = 32'hf561_8c50;
      errors       = 0;
      tests_passed = 0;
      tests_failed = 0;
      wait (arst_n === 1'b1);
      repeat (2) @(negedge clk);
      register_access();
      single_pulse();
      negative_slew();
      multi_channel();
      restart_ignored();
      $display("Summary: %0d tests ok, %0d tests failed, %0d assertion failures",
               tests_passed, tests_failed, u_dut.u_props.fail_count);
      if (tests_failed == 0 && errors == 0 && u_dut.u_props.fail_count == 0) begin
         $display("ALL TESTS PASSED");
      end else begin
         $display("SOME TESTS FAILED");
      end
      $finish;
   end

   // Watchdog
   initial begin
      #(WATCHDOG_CYCLES * CLK_PERIOD_NS);
      $display("ERROR: timeout, tests still running after %0d cycles", WATCHDOG_CYCLES);
      $display("SOME TESTS FAILED");
      $finish;
   end

endmodule

// File: tests/tb_clock.sv
// ------------------------------
// Testbench clock and reset
// Free-running clock, reset held
// low for a number of cycles
// ------------------------------
module tb_clock #(
   parameter int PERIOD_NS    = 10,
   parameter int RESET_CYCLES = 8
) (
   output logic clk,
   output logic arst_n
);
   timeunit 1ns;
   timeprecision 1ps;

   initial begin
      clk = 1'b0;
      forever #(PERIOD_NS / 2) clk = ~clk;
   end

   initial begin
      arst_n = 1'b0;
      repeat (RESET_CYCLES) @(posedge clk);
      @(negedge clk);
      arst_n = 1'b1;  // Release away from the active edge
   end

endmodule
